/* include/flashCache_defs.svh */
`ifndef FLASHCACHE_DEFS_SVH
`define FLASHCACHE_DEFS_SVH

// Flash side
`define FLASH_ADDR_W 24
`define WORD_W 32

// Cache geometry, the SRAM word address is page index then word offset
`define SRAM_ADDR_W 9
`define PAGE_INDEX_W 3
`define WORD_OFFSET_W 6
`define PAGE_TAG_W 16
`define PAGES 8

// Serial reader
`define SPI_COMMAND_W 8

`endif

/* hw/flashCachePkg.sv */
`include "flashCache_defs.svh"

package flashCachePkg;

	// Byte address on the flash
	typedef logic [`FLASH_ADDR_W-1:0] flashAddr_t;

	typedef logic [`WORD_W-1:0] word_t;

	// Page index in the upper bits, word offset below
	typedef logic [`SRAM_ADDR_W-1:0] sramAddr_t;

	typedef logic [`PAGE_INDEX_W-1:0] pageIndex_t;
	typedef logic [`PAGE_TAG_W-1:0] pageTag_t;
	typedef logic [`WORD_OFFSET_W-1:0] wordOffset_t;

	// One extra bit so a full page reads as 64
	typedef logic [`WORD_OFFSET_W:0] fillCount_t;

endpackage

/* hw/spiFlashPkg.sv */
`include "flashCache_defs.svh"

package spiFlashPkg;

	// Reader sequence, gap keeps chip select high between bursts
	typedef enum logic [2:0] {
		spiIdle,
		spiCommand,
		spiAddress,
		spiData,
		spiGap
	} spiState_t;

	// Single lane read
	localparam logic [`SPI_COMMAND_W-1:0] flashReadCommand = 8'h03;

endpackage

/* hw/BinaryTreePLRU.sv */
`timescale 1ns/100ps
`include "flashCache_defs.svh"

module BinaryTreePLRU (
	input logic clk,
	input logic rst,
	input logic access,
	input flashCachePkg::pageIndex_t accessIndex,
	output flashCachePkg::pageIndex_t victimIndex
);

	// Heap order, node 0 is the root and node n has children 2n+1 and 2n+2
	logic [`PAGES-2:0] tree;
	logic rootBit;
	logic midBit;

	always_ff @(posedge clk) begin
		if (rst) begin
			tree <= '0;
		end else if (access) begin
			// Each node on the path points to the other half
			tree[0] <= ~accessIndex[2];
			tree[1 + accessIndex[2]] <= ~accessIndex[1];
			tree[3 + accessIndex[2:1]] <= ~accessIndex[0];
		end
	end

	// Walk from the root towards the least recent leaf
	assign rootBit = tree[0];
	assign midBit = tree[1 + rootBit];
	assign victimIndex = {rootBit, midBit, tree[3 + {rootBit, midBit}]};

endmodule

/* hw/FlashPage.sv */
`timescale 1ns/100ps
`include "flashCache_defs.svh"

module FlashPage (
	input logic clk,
	input logic rst,

	// Replacement
	input logic allocate,
	input flashCachePkg::pageTag_t newTag,

	// Fill progress
	input logic loading,
	input logic wordWritten,

	// Lookup from the read port
	input flashCachePkg::pageTag_t lookupTag,
	input flashCachePkg::wordOffset_t lookupOffset,
	output logic hit,
	output logic wordReady,

	// Loader side
	output logic requestLoad,
	output flashCachePkg::flashAddr_t fillAddress,
	output flashCachePkg::wordOffset_t fillOffset
);

	import flashCachePkg::*;

	logic valid;
	pageTag_t tag;
	fillCount_t count;
	logic full;

	assign full = count[`WORD_OFFSET_W];

	always_ff @(posedge clk) begin
		if (rst) begin
			valid <= 1'b0;
			count <= '0;
		end else if (allocate) begin
			valid <= 1'b1;
			count <= '0;
		end else if (loading && wordWritten && !full) begin
			count <= count + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (allocate) begin
			tag <= newTag;
		end
	end

	assign hit = valid && (tag == lookupTag);

	// Words fill in order, so everything below the count is present
	assign wordReady = hit && (fillCount_t'(lookupOffset) < count);

	// Partly filled pages keep asking until they are complete
	assign requestLoad = valid && !full;

	assign fillOffset = count[`WORD_OFFSET_W-1:0];

	// Next word to fetch, as a byte address
	assign fillAddress = {tag, fillOffset, 2'b00};

endmodule

/* hw/FlashCache.sv */
`timescale 1ns/100ps
`include "flashCache_defs.svh"

module FlashCache (
	input logic clk,
	input logic rst,

	// Processor port
	input logic readEnable,
	input flashCachePkg::flashAddr_t readAddress,
	output logic readReady,

	// SRAM
	output logic sramReadEnable,
	output logic sramWriteEnable,
	output flashCachePkg::sramAddr_t sramReadAddress,
	output flashCachePkg::sramAddr_t sramWriteAddress,

	// Flash reader
	output flashCachePkg::flashAddr_t flashAddress,
	output logic flashChangeAddress,
	output logic flashRequestData,
	input logic flashDataValid,
	input logic flashBusy,

	output logic filling
);

	import flashCachePkg::*;

	logic [`PAGES-1:0] pageHit;
	logic [`PAGES-1:0] pageWordReady;
	logic [`PAGES-1:0] pageRequestLoad;
	flashAddr_t pageFillAddress [`PAGES];
	wordOffset_t pageFillOffset [`PAGES];

	pageTag_t lookupTag;
	wordOffset_t lookupOffset;
	pageIndex_t hitIndex;
	pageIndex_t resumeIndex;
	pageIndex_t victimIndex;
	pageIndex_t loadingIndex;
	pageIndex_t readPageIndex;
	logic anyHit;
	logic resumeFound;
	logic request;
	logic missAllocate;
	logic loadActive;
	logic changePulse;
	logic plruAccess;

	assign lookupTag = readAddress[`FLASH_ADDR_W-1 -: `PAGE_TAG_W];
	assign lookupOffset = readAddress[`WORD_OFFSET_W+1:2];

	// No new lookup in the cycle that returns data
	assign request = readEnable && !readReady;
	assign missAllocate = request && !anyHit;

	BinaryTreePLRU u_BinaryTreePLRU (
		.clk(clk),
		.rst(rst),
		.access(plruAccess),
		.accessIndex(readReady ? readPageIndex : victimIndex),
		.victimIndex(victimIndex)
	);

	for (genvar p = 0; p < `PAGES; p++) begin : gPage
		FlashPage u_FlashPage (
			.clk(clk),
			.rst(rst),
			.allocate(missAllocate && (victimIndex == pageIndex_t'(p))),
			.newTag(lookupTag),
			.loading(loadActive && (loadingIndex == pageIndex_t'(p))),
			.wordWritten(sramWriteEnable),
			.lookupTag(lookupTag),
			.lookupOffset(lookupOffset),
			.hit(pageHit[p]),
			.wordReady(pageWordReady[p]),
			.requestLoad(pageRequestLoad[p]),
			.fillAddress(pageFillAddress[p]),
			.fillOffset(pageFillOffset[p])
		);
	end

	// Lowest index wins for both the hit and the resume choice
	always_comb begin
		hitIndex = '0;
		anyHit = 1'b0;
		resumeIndex = '0;
		resumeFound = 1'b0;
		for (int i = `PAGES - 1; i >= 0; i--) begin
			if (pageHit[i]) begin
				hitIndex = pageIndex_t'(i);
				anyHit = 1'b1;
			end
			if (pageRequestLoad[i]) begin
				resumeIndex = pageIndex_t'(i);
				resumeFound = 1'b1;
			end
		end
		// A waiting read pulls its own page forward
		if (request && anyHit && pageRequestLoad[hitIndex]) begin
			resumeIndex = hitIndex;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			readReady <= 1'b0;
			loadActive <= 1'b0;
			changePulse <= 1'b0;
			loadingIndex <= '0;
		end else begin
			readReady <= sramReadEnable;
			changePulse <= 1'b0;
			if (missAllocate) begin
				// Preempt whatever is loading
				loadingIndex <= victimIndex;
				loadActive <= 1'b1;
				changePulse <= 1'b1;
			end else if (!loadActive && resumeFound) begin
				loadingIndex <= resumeIndex;
				loadActive <= 1'b1;
				changePulse <= 1'b1;
			end else if (loadActive && !pageRequestLoad[loadingIndex]) begin
				loadActive <= 1'b0;
			end
		end
	end

	// Page of the read in flight, for the PLRU update
	always_ff @(posedge clk) begin
		if (sramReadEnable) begin
			readPageIndex <= hitIndex;
		end
	end

	assign plruAccess = missAllocate || readReady;

	assign sramReadEnable = request && pageWordReady[hitIndex];
	assign sramReadAddress = {hitIndex, lookupOffset};

	// Address goes out a cycle after the switch, once the page state has settled
	assign flashAddress = pageFillAddress[loadingIndex];
	assign flashChangeAddress = changePulse;
	assign flashRequestData = loadActive && pageRequestLoad[loadingIndex];

	// Only words of the current stream reach the SRAM
	assign sramWriteEnable = flashDataValid && flashRequestData && !flashBusy && !changePulse;
	assign sramWriteAddress = {loadingIndex, pageFillOffset[loadingIndex]};

	assign filling = loadActive;

endmodule

/* hw/CacheSram.sv */
`timescale 1ns/100ps
`include "flashCache_defs.svh"

module CacheSram (
	input logic clk,
	input logic writeEnable,
	input flashCachePkg::sramAddr_t writeAddress,
	input flashCachePkg::word_t writeData,
	input logic readEnable,
	input flashCachePkg::sramAddr_t readAddress,
	output flashCachePkg::word_t readData
);

	import flashCachePkg::*;

	word_t mem [1 << `SRAM_ADDR_W];

	always_ff @(posedge clk) begin
		if (writeEnable) begin
			mem[writeAddress] <= writeData;
		end
		// Read data lands one cycle after the enable
		if (readEnable) begin
			readData <= mem[readAddress];
		end
	end

endmodule

/* hw/SpiFlashReader.sv */
`timescale 1ns/100ps
`include "flashCache_defs.svh"

module SpiFlashReader (
	input logic clk,
	input logic rst,
	input flashCachePkg::flashAddr_t address,
	input logic changeAddress,
	input logic requestData,
	output logic dataValid,
	output flashCachePkg::word_t data,
	output logic busy,
	output logic spiCs,
	output logic spiClk,
	output logic spiMosi,
	input logic spiMiso
);

	import flashCachePkg::*;
	import spiFlashPkg::*;

	spiState_t state;
	// Command and address go out of the top, read bits come in at the bottom
	word_t shiftReg;
	logic [$clog2(`WORD_W)-1:0] bitCount;
	// Second half of a serial clock period
	logic phase;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= spiIdle;
			phase <= 1'b0;
			bitCount <= '0;
			dataValid <= 1'b0;
			busy <= 1'b0;
		end else begin
			dataValid <= 1'b0;
			if (changeAddress) begin
				state <= spiGap;
				phase <= 1'b0;
				busy <= 1'b1;
			end else begin
				case (state)
					spiIdle: begin
						phase <= 1'b0;
					end
					spiGap: begin
						phase <= !phase;
						bitCount <= '0;
						// Busy here means a new command is due
						if (phase) begin
							state <= busy ? spiCommand : spiIdle;
						end
					end
					spiCommand, spiAddress, spiData: begin
						phase <= !phase;
						if (phase) begin
							bitCount <= bitCount + 1'b1;
							if (state == spiCommand && bitCount == `SPI_COMMAND_W - 1) begin
								state <= spiAddress;
							end
							if (state == spiAddress && &bitCount) begin
								state <= spiData;
							end
							if (state == spiData && &bitCount) begin
								dataValid <= 1'b1;
								busy <= 1'b0;
							end
						end
						// Burst ends as soon as no more words are wanted
						if (state == spiData && !requestData) begin
							state <= spiGap;
							phase <= 1'b0;
						end
					end
					default: begin
						state <= spiIdle;
					end
				endcase
			end
		end
	end

	always_ff @(posedge clk) begin
		if (changeAddress) begin
			shiftReg <= {flashReadCommand, address};
		end else if (phase && !spiCs) begin
			// Sample just before the falling serial edge
			shiftReg <= {shiftReg[`WORD_W-2:0], spiMiso};
		end
	end

	assign data = shiftReg;

	assign spiCs = (state == spiIdle) || (state == spiGap);
	assign spiClk = phase && !spiCs;
	assign spiMosi = (state == spiCommand || state == spiAddress) ? shiftReg[`WORD_W-1] : 1'b0;

endmodule

/* hw/FlashCacheTop.sv */
`timescale 1ns/100ps

module FlashCacheTop (
	input logic clk,
	input logic rst,
	input logic readEnable,
	input flashCachePkg::flashAddr_t readAddress,
	output logic readReady,
	output flashCachePkg::word_t readData,
	output logic filling,
	output logic spiCs,
	output logic spiClk,
	output logic spiMosi,
	input logic spiMiso
);

	import flashCachePkg::*;

	logic sramReadEnable;
	logic sramWriteEnable;
	sramAddr_t sramReadAddress;
	sramAddr_t sramWriteAddress;

	flashAddr_t flashAddress;
	logic flashChangeAddress;
	logic flashRequestData;
	logic flashDataValid;
	logic flashBusy;
	word_t flashData;

	FlashCache u_FlashCache (
		.clk(clk),
		.rst(rst),
		.readEnable(readEnable),
		.readAddress(readAddress),
		.readReady(readReady),
		.sramReadEnable(sramReadEnable),
		.sramWriteEnable(sramWriteEnable),
		.sramReadAddress(sramReadAddress),
		.sramWriteAddress(sramWriteAddress),
		.flashAddress(flashAddress),
		.flashChangeAddress(flashChangeAddress),
		.flashRequestData(flashRequestData),
		.flashDataValid(flashDataValid),
		.flashBusy(flashBusy),
		.filling(filling)
	);

	// Flash words are written straight from the reader
	CacheSram u_CacheSram (
		.clk(clk),
		.writeEnable(sramWriteEnable),
		.writeAddress(sramWriteAddress),
		.writeData(flashData),
		.readEnable(sramReadEnable),
		.readAddress(sramReadAddress),
		.readData(readData)
	);

	SpiFlashReader u_SpiFlashReader (
		.clk(clk),
		.rst(rst),
		.address(flashAddress),
		.changeAddress(flashChangeAddress),
		.requestData(flashRequestData),
		.dataValid(flashDataValid),
		.data(flashData),
		.busy(flashBusy),
		.spiCs(spiCs),
		.spiClk(spiClk),
		.spiMosi(spiMosi),
		.spiMiso(spiMiso)
	);

endmodule

/* testbench/spiFlashModel.sv */
`timescale 1ns/100ps
`include "flashCache_defs.svh"

module spiFlashModel (
	input logic spiCs,
	input logic spiClk,
	input logic spiMosi,
	output logic spiMiso
);

	import spiFlashPkg::*;

	// Command byte then byte address, most significant bit first
	logic [`SPI_COMMAND_W+`FLASH_ADDR_W-1:0] header;
	int headerBits;
	logic streaming;
	logic [`FLASH_ADDR_W-1:0] byteAddress;
	int bitIndex;
	logic [7:0] currentByte;

	// Contents rule, low address byte XOR the next one up
	function automatic logic [7:0] contentAt(input logic [`FLASH_ADDR_W-1:0] a);
		return a[7:0] ^ a[15:8];
	endfunction

	initial begin
		spiMiso = 1'b0;
		header = '0;
		headerBits = 0;
		streaming = 1'b0;
		byteAddress = '0;
		bitIndex = 7;
	end

	// Chip select high ends the transaction
	always @(posedge spiCs) begin
		headerBits = 0;
		streaming = 1'b0;
	end

	always @(posedge spiClk) begin
		if (!spiCs && headerBits < `SPI_COMMAND_W + `FLASH_ADDR_W) begin
			header = {header[`SPI_COMMAND_W+`FLASH_ADDR_W-2:0], spiMosi};
			headerBits = headerBits + 1;
		end
	end

	// Out on the falling edge, the reader takes it at the next falling edge
	always @(negedge spiClk) begin
		if (!spiCs && headerBits == `SPI_COMMAND_W + `FLASH_ADDR_W
				&& header[`SPI_COMMAND_W+`FLASH_ADDR_W-1 -: `SPI_COMMAND_W] == flashReadCommand) begin
			if (!streaming) begin
				streaming = 1'b1;
				byteAddress = header[`FLASH_ADDR_W-1:0];
				bitIndex = 7;
			end else if (bitIndex == 0) begin
				byteAddress = byteAddress + 1'b1;
				bitIndex = 7;
			end else begin
				bitIndex = bitIndex - 1;
			end
			currentByte = contentAt(byteAddress);
			spiMiso = currentByte[bitIndex];
		end
	end

endmodule

/* testbench/tbFlashCache.sv */
`timescale 1ns/100ps
`include "flashCache_defs.svh"

module tbFlashCache;

	import flashCachePkg::*;

	localparam int resetCycles = 16;
	localparam int readTimeout = 12000;
	localparam int fillTimeout = 40000;
	localparam int quietCycles = 4;

	logic clk;
	logic rst;
	logic readEnable;
	flashAddr_t readAddress;
	logic readReady;
	word_t readData;
	logic filling;
	logic spiCs;
	logic spiClk;
	logic spiMosi;
	logic spiMiso;

	int errorCount;
	int checkCount;
	int testStartErrors;
	integer seed;

	FlashCacheTop u_FlashCacheTop (
		.clk(clk),
		.rst(rst),
		.readEnable(readEnable),
		.readAddress(readAddress),
		.readReady(readReady),
		.readData(readData),
		.filling(filling),
		.spiCs(spiCs),
		.spiClk(spiClk),
		.spiMosi(spiMosi),
		.spiMiso(spiMiso)
	);

	spiFlashModel u_spiFlashModel (
		.spiCs(spiCs),
		.spiClk(spiClk),
		.spiMosi(spiMosi),
		.spiMiso(spiMiso)
	);

	always #5 clk = !clk;

	function automatic logic [7:0] flashByte(input flashAddr_t a);
		return a[7:0] ^ a[15:8];
	endfunction

	// Big endian word from the four bytes at the aligned address
	function automatic word_t expectedWord(input flashAddr_t addr);
		flashAddr_t base;
		word_t result;
		base = {addr[`FLASH_ADDR_W-1:2], 2'b00};
		result = '0;
		for (int i = 0; i < 4; i++) begin
			result = {result[`WORD_W-9:0], flashByte(base + flashAddr_t'(i))};
		end
		return result;
	endfunction

	function automatic flashAddr_t pageAddr(input pageTag_t tag, input int word,
			input logic [1:0] byteSel);
		return {tag, wordOffset_t'(word), byteSel};
	endfunction

	// Holds the request until readReady, cycles counts falling edges to it
	task automatic readWord(input flashAddr_t addr, output word_t data, output int cycles,
			output bit sawFilling, output bit timedOut);
		bit done;
		done = 1'b0;
		cycles = 0;
		sawFilling = 1'b0;
		data = '0;
		@(negedge clk);
		readEnable = 1'b1;
		readAddress = addr;
		while (!done && cycles < readTimeout) begin
			@(negedge clk);
			cycles++;
			if (readReady) begin
				done = 1'b1;
				data = readData;
			end else if (filling) begin
				sawFilling = 1'b1;
			end
		end
		readEnable = 1'b0;
		timedOut = !done;
	endtask

	task automatic readAndCompare(input flashAddr_t addr, input bit expectHit);
		word_t data;
		int cycles;
		bit sawFilling;
		bit timedOut;
		readWord(addr, data, cycles, sawFilling, timedOut);
		checkCount++;
		if (timedOut) begin
			errorCount++;
			$display("No readReady for address %h within %0d cycles", addr, readTimeout);
		end else begin
			if (data !== expectedWord(addr)) begin
				errorCount++;
				$display("Error at %0t: readData = %h, expected %h (address %h)",
					$time, data, expectedWord(addr), addr);
			end
			if (expectHit && cycles != 1) begin
				errorCount++;
				$display("Error at %0t: readReady latency = %0d, expected 1 (address %h)",
					$time, cycles, addr);
			end
		end
	endtask

	task automatic verifyIdleOutputs();
		checkCount++;
		if (readReady !== 1'b0) begin
			errorCount++;
			$display("Error at %0t: readReady = %b, expected 0", $time, readReady);
		end
		if (filling !== 1'b0) begin
			errorCount++;
			$display("Error at %0t: filling = %b, expected 0", $time, filling);
		end
		if (spiCs !== 1'b1) begin
			errorCount++;
			$display("Error at %0t: spiCs = %b, expected 1", $time, spiCs);
		end
	endtask

	// Filling drops for a cycle between pages, so wait for a quiet run
	task automatic waitLoaderIdle();
		int cycles;
		int quiet;
		cycles = 0;
		quiet = 0;
		while (quiet < quietCycles && cycles < fillTimeout) begin
			@(negedge clk);
			cycles++;
			quiet = filling ? 0 : quiet + 1;
		end
		checkCount++;
		if (quiet < quietCycles) begin
			errorCount++;
			$display("Loader still filling after %0d cycles", cycles);
		end
	endtask

	task automatic finishTest(input string name);
		$display("%s: %0d errors", name, errorCount - testStartErrors);
	endtask

	task automatic resetAndFirstMiss();
		word_t data;
		int cycles;
		bit sawFilling;
		bit timedOut;
		flashAddr_t addr;
		testStartErrors = errorCount;
		rst = 1'b1;
		for (int i = 0; i < resetCycles; i++) begin
			@(negedge clk);
			verifyIdleOutputs();
		end
		rst = 1'b0;
		repeat (quietCycles) begin
			@(negedge clk);
			verifyIdleOutputs();
		end
		addr = pageAddr(16'h0012, 5, 2'd1);
		readWord(addr, data, cycles, sawFilling, timedOut);
		checkCount++;
		if (timedOut) begin
			errorCount++;
			$display("No readReady for the first read within %0d cycles", readTimeout);
		end else if (!sawFilling) begin
			errorCount++;
			$display("First read returned before filling rose, so it was not handled as a miss");
		end else if (data !== expectedWord(addr)) begin
			errorCount++;
			$display("Error at %0t: readData = %h, expected %h", $time, data, expectedWord(addr));
		end
		finishTest("reset state and first miss");
	endtask

	task automatic coldMissData();
		testStartErrors = errorCount;
		readAndCompare(pageAddr(16'h1234, 0, 2'd0), 1'b0);
		readAndCompare(pageAddr(16'h1234, 63, 2'd3), 1'b0);
		finishTest("cold miss data");
	endtask

	task automatic loadedWordHits();
		testStartErrors = errorCount;
		waitLoaderIdle();
		for (int w = 0; w < 64; w++) begin
			readAndCompare(pageAddr(16'h1234, w, 2'(w)), 1'b1);
		end
		finishTest("loaded word hit timing");
	endtask

	task automatic replacementKeepsRecent();
		testStartErrors = errorCount;
		for (int k = 0; k < 8; k++) begin
			readAndCompare(pageAddr(16'h2200 + pageTag_t'(k * 3), 63, 2'd0), 1'b0);
			waitLoaderIdle();
		end
		readAndCompare(pageAddr(16'h2200, 10, 2'd0), 1'b1);
		// Ninth page must evict something other than the page just read
		readAndCompare(pageAddr(16'h2300, 63, 2'd0), 1'b0);
		waitLoaderIdle();
		readAndCompare(pageAddr(16'h2200, 20, 2'd2), 1'b1);
		finishTest("replacement keeps recent pages");
	endtask

	task automatic preemptAndResume();
		testStartErrors = errorCount;
		readAndCompare(pageAddr(16'h4a5c, 0, 2'd0), 1'b0);
		checkCount++;
		if (filling !== 1'b1) begin
			errorCount++;
			$display("Page X was no longer filling when page Y was requested");
		end
		readAndCompare(pageAddr(16'h7c31, 63, 2'd1), 1'b0);
		waitLoaderIdle();
		for (int w = 0; w < 64; w++) begin
			readAndCompare(pageAddr(16'h4a5c, w, 2'd0), 1'b1);
		end
		finishTest("preemption and resume");
	endtask

	task automatic randomReads();
		int page;
		logic [7:0] low;
		testStartErrors = errorCount;
		for (int i = 0; i < 40; i++) begin
			page = $unsigned($random(seed)) % 12;
			low = 8'($random(seed));
			readAndCompare({16'h6000 + pageTag_t'(page * 7), low}, 1'b0);
		end
		finishTest("random reads");
	endtask

	initial begin
		clk = 1'b0;
		rst = 1'b1;
		readEnable = 1'b0;
		readAddress = '0;
		errorCount = 0;
		checkCount = 0;
		testStartErrors = 0;
		seed = 32'h0941_a17b;
		resetAndFirstMiss();
		coldMissData();
		loadedWordHits();
		replacementKeepsRecent();
		preemptAndResume();
		randomReads();
		$display("Checks: %0d, errors: %0d", checkCount, errorCount);
		if (errorCount == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule

/* flashCache.f */
+incdir+include
hw/flashCachePkg.sv
hw/spiFlashPkg.sv
hw/BinaryTreePLRU.sv
hw/FlashPage.sv
hw/FlashCache.sv
hw/CacheSram.sv
hw/SpiFlashReader.sv
hw/FlashCacheTop.sv
testbench/spiFlashModel.sv
testbench/tbFlashCache.sv

/* Bender.yml */
package:
  name: flashCache

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hw/flashCachePkg.sv
      - hw/spiFlashPkg.sv
      - hw/BinaryTreePLRU.sv
      - hw/FlashPage.sv
      - hw/FlashCache.sv
      - hw/CacheSram.sv
      - hw/SpiFlashReader.sv
      - hw/FlashCacheTop.sv
  - target: test
    include_dirs:
      - include
    files:
      - testbench/spiFlashModel.sv
      - testbench/tbFlashCache.sv
